// ==== logic/dbg_uart_pkg.sv ====
/* Shared types and constants of the serial debug bridge.
   Bit timing is a plain clk divider, so CLKS_PER_BIT should be even and at least 4. */
package dbg_uart_pkg;

	// --------------------------------------------------
	// timing and sizes
	localparam int CLKS_PER_BIT    = 8;
	localparam int BIT_CNT_W       = $clog2(CLKS_PER_BIT);
	localparam int FIFO_DEPTH_LOG2 = 4;
	localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;
	localparam int MEM_WORDS_LOG2  = 6;

	typedef logic [7:0]           byte_t;
	typedef logic [31:0]          word_t;
	typedef logic [3:0]           reg_adr_t;
	typedef logic [3:0]           byte_sel_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// last tick of a full bit and of a half bit
	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_cnt_t BIT_HALF = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

	// --------------------------------------------------
	// debug registers with a special meaning
	localparam reg_adr_t DBG_REG_ADDR = 4'd2;
	localparam reg_adr_t DBG_REG_DBUS = 4'd6;

	// host commands and their replies
	localparam byte_t CMD_NOP       = 8'h00;
	localparam byte_t CMD_STATUS    = 8'h01;
	localparam byte_t CMD_DBG_WRITE = 8'h02;
	localparam byte_t CMD_DBG_READ  = 8'h03;
	localparam byte_t CMD_MEM_WRITE = 8'h04;
	localparam byte_t CMD_MEM_READ  = 8'h05;

	localparam byte_t ACK_NOP       = 8'h80;
	localparam byte_t ACK_STATUS    = 8'h81;
	localparam byte_t ACK_DBG_WRITE = 8'h82;
	localparam byte_t ACK_DBG_READ  = 8'h83;
	localparam byte_t ACK_MEM_WRITE = 8'h84;
	localparam byte_t ACK_MEM_READ  = 8'h85;

	typedef enum logic [4:0] {
		ST_IDLE, ST_NOP_ACK, ST_STAT_ACK, ST_STAT_DATA,
		ST_DBG_ADR, ST_DW_DATA, ST_DBG_BUS, ST_DW_ACK, ST_DR_ACK, ST_DR_DATA,
		ST_MEM_SIZE, ST_MEM_ADDR, ST_MEM_SET, ST_MW_DATA, ST_MEM_BUS,
		ST_MW_ACK, ST_MR_ACK, ST_MR_DATA
	} cmd_state_t;

endpackage

// ==== logic/uart_fifo.sv ====
/* Byte FIFO with valid/ready on both sides. A write while full is not taken,
   so a writer that ignores ready loses the byte. */
`timescale 1ns/100ps

module uart_fifo (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr_valid_i,
	input  dbg_uart_pkg::byte_t wr_data_i,
	output logic               wr_ready_o,
	output logic               rd_valid_o,
	output dbg_uart_pkg::byte_t rd_data_o,
	input  logic               rd_ready_i
);

	localparam int AW = dbg_uart_pkg::FIFO_DEPTH_LOG2;

	dbg_uart_pkg::byte_t mem [dbg_uart_pkg::FIFO_DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] level;

	// extra pointer bit tells full from empty
	assign level      = wr_ptr - rd_ptr;
	assign wr_ready_o = ~level[AW];
	assign rd_valid_o = (level != '0);
	assign rd_data_o  = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_valid_i && wr_ready_o)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_valid_o && rd_ready_i)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid_i && wr_ready_o)
			mem[wr_ptr[AW-1:0]] <= wr_data_i;
	end

	// a waiting read keeps its byte until it is taken
	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		(rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_data_o)));

endmodule

// ==== logic/uart_tx.sv ====
/* 8N1 serializer. Takes one byte when idle and is busy for ten bit times. */
`timescale 1ns/100ps

module uart_tx (
	input  logic               clk,
	input  logic               reset,
	input  logic               tx_valid_i,
	input  dbg_uart_pkg::byte_t tx_data_i,
	output logic               tx_ready_o,
	output logic               serial_o
);

	logic                   busy;
	dbg_uart_pkg::bit_cnt_t tick;
	logic [3:0]             bit_idx;
	logic [9:0]             shreg;

	assign tx_ready_o = ~busy;
	// shift register idles at all ones so the line stays high
	assign serial_o   = shreg[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy    <= 1'b0;
			tick    <= '0;
			bit_idx <= '0;
			shreg   <= '1;
		end else if (!busy) begin
			if (tx_valid_i) begin
				busy    <= 1'b1;
				tick    <= '0;
				bit_idx <= '0;
				// stop, data lsb first, start
				shreg   <= {1'b1, tx_data_i, 1'b0};
			end
		end else if (tick == dbg_uart_pkg::BIT_LAST) begin
			tick  <= '0;
			shreg <= {1'b1, shreg[9:1]};
			if (bit_idx == 4'd9)
				busy <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end else begin
			tick <= tick + 1'b1;
		end
	end

endmodule

// ==== logic/uart_rx.sv ====
/* 8N1 deserializer sampling at bit centers. A frame with a low stop bit is
   dropped, and a start bit shorter than half a bit is ignored. */
`timescale 1ns/100ps

module uart_rx (
	input  logic               clk,
	input  logic               reset,
	input  logic               serial_i,
	output logic               rx_valid_o,
	output dbg_uart_pkg::byte_t rx_data_o
);

	logic [1:0]             sync_q;
	logic                   line_q;
	logic                   busy;
	dbg_uart_pkg::bit_cnt_t tick;
	dbg_uart_pkg::bit_cnt_t tick_end;
	logic [3:0]             bit_idx;
	logic                   sample;
	dbg_uart_pkg::byte_t    shreg;

	// half a bit to the start bit center, then whole bits
	assign tick_end  = (bit_idx == 4'd0) ? dbg_uart_pkg::BIT_HALF : dbg_uart_pkg::BIT_LAST;
	assign sample    = busy && (tick == tick_end);
	assign rx_data_o = shreg;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_q     <= 2'b11;
			line_q     <= 1'b1;
			busy       <= 1'b0;
			tick       <= '0;
			bit_idx    <= '0;
			rx_valid_o <= 1'b0;
		end else begin
			sync_q     <= {sync_q[0], serial_i};
			line_q     <= sync_q[1];
			rx_valid_o <= 1'b0;
			if (!busy) begin
				// falling edge starts a frame
				if (line_q && !sync_q[1]) begin
					busy    <= 1'b1;
					tick    <= '0;
					bit_idx <= '0;
				end
			end else if (sample) begin
				tick    <= '0;
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0) begin
					// line back high means a glitch
					if (sync_q[1])
						busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy       <= 1'b0;
					rx_valid_o <= sync_q[1];
				end
			end else begin
				tick <= tick + 1'b1;
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
			shreg <= {sync_q[1], shreg[7:1]};
	end

endmodule

// ==== logic/uart_core.sv ====
/* UART with a FIFO on each side. Received bytes are dropped while the
   receive FIFO is full. */
`timescale 1ns/100ps

module uart_core (
	input  logic               clk,
	input  logic               reset,
	input  logic               uart_rx_i,
	output logic               uart_tx_o,
	output logic               rx_valid_o,
	output dbg_uart_pkg::byte_t rx_data_o,
	input  logic               rx_ready_i,
	input  logic               tx_valid_i,
	input  dbg_uart_pkg::byte_t tx_data_i,
	output logic               tx_ready_o
);

	logic                rx_byte_valid;
	dbg_uart_pkg::byte_t rx_byte;
	logic                txq_valid;
	dbg_uart_pkg::byte_t txq_data;
	logic                txq_ready;

	// --------------------------------------------------
	// receive path
	uart_rx u_rx (
		.clk        (clk),
		.reset      (reset),
		.serial_i   (uart_rx_i),
		.rx_valid_o (rx_byte_valid),
		.rx_data_o  (rx_byte)
	);

	uart_fifo u_rx_fifo (
		.clk        (clk),
		.reset      (reset),
		.wr_valid_i (rx_byte_valid),
		.wr_data_i  (rx_byte),
		.wr_ready_o (),
		.rd_valid_o (rx_valid_o),
		.rd_data_o  (rx_data_o),
		.rd_ready_i (rx_ready_i)
	);

	// --------------------------------------------------
	// transmit path
	uart_fifo u_tx_fifo (
		.clk        (clk),
		.reset      (reset),
		.wr_valid_i (tx_valid_i),
		.wr_data_i  (tx_data_i),
		.wr_ready_o (tx_ready_o),
		.rd_valid_o (txq_valid),
		.rd_data_o  (txq_data),
		.rd_ready_i (txq_ready)
	);

	uart_tx u_tx (
		.clk        (clk),
		.reset      (reset),
		.tx_valid_i (txq_valid),
		.tx_data_i  (txq_data),
		.tx_ready_o (txq_ready),
		.serial_o   (uart_tx_o)
	);

endmodule

// ==== logic/dbg_cmd_engine.sv ====
/* Host command decoder driving the debug bus. Unknown command bytes are
   consumed and ignored. endian_i must stay stable during a command. */
`timescale 1ns/100ps

module dbg_cmd_engine (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    endian_i,
	input  logic                    rx_valid_i,
	input  dbg_uart_pkg::byte_t     rx_data_i,
	output logic                    rx_ready_o,
	output logic                    tx_valid_o,
	output dbg_uart_pkg::byte_t     tx_data_o,
	input  logic                    tx_ready_i,
	output dbg_uart_pkg::reg_adr_t  dbg_adr_o,
	output dbg_uart_pkg::byte_sel_t dbg_sel_o,
	output logic                    dbg_we_o,
	output dbg_uart_pkg::word_t     dbg_wdata_o,
	output logic                    dbg_stb_o,
	input  dbg_uart_pkg::word_t     dbg_rdata_i,
	input  logic                    dbg_ack_i
);

	dbg_uart_pkg::cmd_state_t state;
	logic                     is_wr;
	logic [1:0]               fcnt;
	dbg_uart_pkg::byte_t      count;
	dbg_uart_pkg::byte_t      size;
	dbg_uart_pkg::word_t      address;
	dbg_uart_pkg::word_t      rdata_q;
	logic [1:0]               flane;
	logic [1:0]               mlane;
	dbg_uart_pkg::byte_sel_t  msel;

	// byte lane of a field byte and of a memory byte, in endian order
	assign flane = fcnt ^ {2{endian_i}};
	assign mlane = address[1:0] ^ {2{endian_i}};
	assign msel  = dbg_uart_pkg::byte_sel_t'(4'b0001 << mlane);

	// --------------------------------------------------
	// stream handshakes
	always_comb begin
		rx_ready_o = 1'b0;
		tx_valid_o = 1'b0;
		tx_data_o  = '0;
		case (state)
			dbg_uart_pkg::ST_IDLE, dbg_uart_pkg::ST_DBG_ADR, dbg_uart_pkg::ST_DW_DATA,
			dbg_uart_pkg::ST_MEM_SIZE, dbg_uart_pkg::ST_MEM_ADDR,
			dbg_uart_pkg::ST_MW_DATA:
				rx_ready_o = 1'b1;
			dbg_uart_pkg::ST_NOP_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_NOP;
			end
			dbg_uart_pkg::ST_STAT_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_STATUS;
			end
			dbg_uart_pkg::ST_STAT_DATA: begin
				tx_valid_o = 1'b1;
				tx_data_o  = {7'd0, endian_i};
			end
			dbg_uart_pkg::ST_DW_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_DBG_WRITE;
			end
			dbg_uart_pkg::ST_DR_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_DBG_READ;
			end
			dbg_uart_pkg::ST_DR_DATA: begin
				tx_valid_o = 1'b1;
				tx_data_o  = rdata_q[8*flane +: 8];
			end
			dbg_uart_pkg::ST_MW_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_MEM_WRITE;
			end
			dbg_uart_pkg::ST_MR_ACK: begin
				tx_valid_o = 1'b1;
				tx_data_o  = dbg_uart_pkg::ACK_MEM_READ;
			end
			dbg_uart_pkg::ST_MR_DATA: begin
				tx_valid_o = 1'b1;
				tx_data_o  = rdata_q[8*mlane +: 8];
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// command FSM
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= dbg_uart_pkg::ST_IDLE;
			is_wr       <= 1'b0;
			fcnt        <= '0;
			count       <= '0;
			size        <= '0;
			address     <= '0;
			rdata_q     <= '0;
			dbg_adr_o   <= '0;
			dbg_sel_o   <= '0;
			dbg_we_o    <= 1'b0;
			dbg_wdata_o <= '0;
			dbg_stb_o   <= 1'b0;
		end else begin
			case (state)
				dbg_uart_pkg::ST_IDLE: begin
					fcnt  <= '0;
					count <= '0;
					if (rx_valid_i) begin
						case (rx_data_i)
							dbg_uart_pkg::CMD_NOP:    state <= dbg_uart_pkg::ST_NOP_ACK;
							dbg_uart_pkg::CMD_STATUS: state <= dbg_uart_pkg::ST_STAT_ACK;
							dbg_uart_pkg::CMD_DBG_WRITE, dbg_uart_pkg::CMD_DBG_READ: begin
								is_wr <= (rx_data_i == dbg_uart_pkg::CMD_DBG_WRITE);
								state <= dbg_uart_pkg::ST_DBG_ADR;
							end
							dbg_uart_pkg::CMD_MEM_WRITE, dbg_uart_pkg::CMD_MEM_READ: begin
								is_wr <= (rx_data_i == dbg_uart_pkg::CMD_MEM_WRITE);
								state <= dbg_uart_pkg::ST_MEM_SIZE;
							end
							default: ;
						endcase
					end
				end
				dbg_uart_pkg::ST_NOP_ACK, dbg_uart_pkg::ST_STAT_DATA,
				dbg_uart_pkg::ST_DW_ACK, dbg_uart_pkg::ST_MW_ACK:
					if (tx_ready_i)
						state <= dbg_uart_pkg::ST_IDLE;
				dbg_uart_pkg::ST_STAT_ACK:
					if (tx_ready_i)
						state <= dbg_uart_pkg::ST_STAT_DATA;

				// debug register access, sel in the high nibble
				dbg_uart_pkg::ST_DBG_ADR:
					if (rx_valid_i) begin
						dbg_adr_o <= rx_data_i[3:0];
						dbg_sel_o <= rx_data_i[7:4];
						dbg_we_o  <= is_wr;
						if (is_wr) begin
							state <= dbg_uart_pkg::ST_DW_DATA;
						end else begin
							dbg_stb_o <= 1'b1;
							state     <= dbg_uart_pkg::ST_DBG_BUS;
						end
					end
				dbg_uart_pkg::ST_DW_DATA:
					if (rx_valid_i) begin
						dbg_wdata_o[8*flane +: 8] <= rx_data_i;
						fcnt <= fcnt + 1'b1;
						if (fcnt == 2'd3) begin
							dbg_stb_o <= 1'b1;
							state     <= dbg_uart_pkg::ST_DBG_BUS;
						end
					end
				dbg_uart_pkg::ST_DBG_BUS:
					if (dbg_ack_i) begin
						dbg_stb_o <= 1'b0;
						rdata_q   <= dbg_rdata_i;
						state     <= is_wr ? dbg_uart_pkg::ST_DW_ACK : dbg_uart_pkg::ST_DR_ACK;
					end
				dbg_uart_pkg::ST_DR_ACK:
					if (tx_ready_i)
						state <= dbg_uart_pkg::ST_DR_DATA;
				dbg_uart_pkg::ST_DR_DATA:
					if (tx_ready_i) begin
						fcnt <= fcnt + 1'b1;
						if (fcnt == 2'd3)
							state <= dbg_uart_pkg::ST_IDLE;
					end

				// memory access through the address register and the window
				dbg_uart_pkg::ST_MEM_SIZE:
					if (rx_valid_i) begin
						size  <= rx_data_i;
						state <= dbg_uart_pkg::ST_MEM_ADDR;
					end
				dbg_uart_pkg::ST_MEM_ADDR:
					if (rx_valid_i) begin
						address[8*flane +: 8] <= rx_data_i;
						fcnt <= fcnt + 1'b1;
						if (fcnt == 2'd3)
							state <= is_wr ? dbg_uart_pkg::ST_MEM_SET : dbg_uart_pkg::ST_MR_ACK;
					end
				dbg_uart_pkg::ST_MR_ACK:
					if (tx_ready_i)
						state <= dbg_uart_pkg::ST_MEM_SET;
				dbg_uart_pkg::ST_MEM_SET:
					if (!dbg_stb_o) begin
						dbg_adr_o   <= dbg_uart_pkg::DBG_REG_ADDR;
						dbg_sel_o   <= 4'b1111;
						dbg_we_o    <= 1'b1;
						dbg_wdata_o <= {address[31:2], 2'b00};
						dbg_stb_o   <= 1'b1;
					end else if (dbg_ack_i) begin
						dbg_stb_o <= 1'b0;
						state     <= is_wr ? dbg_uart_pkg::ST_MW_DATA : dbg_uart_pkg::ST_MEM_BUS;
					end
				dbg_uart_pkg::ST_MW_DATA:
					if (rx_valid_i) begin
						dbg_adr_o   <= dbg_uart_pkg::DBG_REG_DBUS;
						dbg_sel_o   <= msel;
						dbg_we_o    <= 1'b1;
						dbg_wdata_o <= {4{rx_data_i}};
						dbg_stb_o   <= 1'b1;
						state       <= dbg_uart_pkg::ST_MEM_BUS;
					end
				dbg_uart_pkg::ST_MEM_BUS:
					// a read is issued here, a write was issued on the data byte
					if (!dbg_stb_o) begin
						dbg_adr_o <= dbg_uart_pkg::DBG_REG_DBUS;
						dbg_sel_o <= msel;
						dbg_we_o  <= 1'b0;
						dbg_stb_o <= 1'b1;
					end else if (dbg_ack_i) begin
						dbg_stb_o <= 1'b0;
						rdata_q   <= dbg_rdata_i;
						if (!is_wr) begin
							state <= dbg_uart_pkg::ST_MR_DATA;
						end else begin
							address <= address + 1'b1;
							count   <= count + 1'b1;
							state   <= (count == size) ? dbg_uart_pkg::ST_MW_ACK
							                           : dbg_uart_pkg::ST_MEM_SET;
						end
					end
				dbg_uart_pkg::ST_MR_DATA:
					if (tx_ready_i) begin
						address <= address + 1'b1;
						count   <= count + 1'b1;
						state   <= (count == size) ? dbg_uart_pkg::ST_IDLE
						                           : dbg_uart_pkg::ST_MEM_SET;
					end
				default: state <= dbg_uart_pkg::ST_IDLE;
			endcase
		end
	end

	// bus strobe is only released by the target's ack
	a_stb_hold: assert property (@(posedge clk) disable iff (reset)
		$fell(dbg_stb_o) |-> $past(dbg_ack_i));

	// a reply byte waits unchanged until the UART core takes it
	a_tx_hold: assert property (@(posedge clk) disable iff (reset)
		(tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_data_o)));

endmodule

// ==== logic/dbg_target.sv ====
/* Model of a CPU debug unit. Memory is 64 words and ignores address bits
   above bit 7, and memory contents are undefined after reset. */
`timescale 1ns/100ps

module dbg_target (
	input  logic                    clk,
	input  logic                    reset,
	input  dbg_uart_pkg::reg_adr_t  dbg_adr_i,
	input  dbg_uart_pkg::byte_sel_t dbg_sel_i,
	input  logic                    dbg_we_i,
	input  dbg_uart_pkg::word_t     dbg_wdata_i,
	input  logic                    dbg_stb_i,
	output dbg_uart_pkg::word_t     dbg_rdata_o,
	output logic                    dbg_ack_o
);

	localparam int MW = dbg_uart_pkg::MEM_WORDS_LOG2;

	dbg_uart_pkg::word_t regs [16];
	dbg_uart_pkg::word_t mem [2 ** MW];
	logic [MW-1:0]       mem_adr;
	logic                access;
	logic                win_sel;
	dbg_uart_pkg::word_t rd_word;

	// one access per strobe, the ack cycle itself is not a new access
	assign access  = dbg_stb_i && !dbg_ack_o;
	assign win_sel = (dbg_adr_i == dbg_uart_pkg::DBG_REG_DBUS);
	assign mem_adr = regs[dbg_uart_pkg::DBG_REG_ADDR][MW+1:2];

	always_comb begin
		if (win_sel)
			rd_word = mem[mem_adr];
		else if (dbg_adr_i == dbg_uart_pkg::DBG_REG_ADDR)
			rd_word = {regs[dbg_uart_pkg::DBG_REG_ADDR][31:2], 2'b00};
		else
			rd_word = regs[dbg_adr_i];
	end

	// --------------------------------------------------
	// register file and ack
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dbg_ack_o <= 1'b0;
			for (int r = 0; r < 16; r++)
				regs[r] <= '0;
		end else begin
			dbg_ack_o <= access;
			if (access && dbg_we_i && !win_sel) begin
				for (int b = 0; b < 4; b++)
					if (dbg_sel_i[b])
						regs[dbg_adr_i][8*b +: 8] <= dbg_wdata_i[8*b +: 8];
			end
		end
	end

	// memory window and read data
	always_ff @(posedge clk) begin
		if (access) begin
			dbg_rdata_o <= rd_word;
			if (dbg_we_i && win_sel) begin
				for (int b = 0; b < 4; b++)
					if (dbg_sel_i[b])
						mem[mem_adr][8*b +: 8] <= dbg_wdata_i[8*b +: 8];
			end
		end
	end

endmodule

// ==== logic/dbg_uart_top.sv ====
/* Serial debug bridge with a model debug target. Bit rate is clk / CLKS_PER_BIT. */
`timescale 1ns/100ps

module dbg_uart_top (
	input  logic clk,
	input  logic reset,
	input  logic endian_i,
	input  logic uart_rx_i,
	output logic uart_tx_o
);

	logic                    rx_valid;
	dbg_uart_pkg::byte_t     rx_data;
	logic                    rx_ready;
	logic                    tx_valid;
	dbg_uart_pkg::byte_t     tx_data;
	logic                    tx_ready;
	dbg_uart_pkg::reg_adr_t  dbg_adr;
	dbg_uart_pkg::byte_sel_t dbg_sel;
	logic                    dbg_we;
	dbg_uart_pkg::word_t     dbg_wdata;
	logic                    dbg_stb;
	dbg_uart_pkg::word_t     dbg_rdata;
	logic                    dbg_ack;

	uart_core u_uart (
		.clk        (clk),
		.reset      (reset),
		.uart_rx_i  (uart_rx_i),
		.uart_tx_o  (uart_tx_o),
		.rx_valid_o (rx_valid),
		.rx_data_o  (rx_data),
		.rx_ready_i (rx_ready),
		.tx_valid_i (tx_valid),
		.tx_data_i  (tx_data),
		.tx_ready_o (tx_ready)
	);

	dbg_cmd_engine u_engine (
		.clk         (clk),
		.reset       (reset),
		.endian_i    (endian_i),
		.rx_valid_i  (rx_valid),
		.rx_data_i   (rx_data),
		.rx_ready_o  (rx_ready),
		.tx_valid_o  (tx_valid),
		.tx_data_o   (tx_data),
		.tx_ready_i  (tx_ready),
		.dbg_adr_o   (dbg_adr),
		.dbg_sel_o   (dbg_sel),
		.dbg_we_o    (dbg_we),
		.dbg_wdata_o (dbg_wdata),
		.dbg_stb_o   (dbg_stb),
		.dbg_rdata_i (dbg_rdata),
		.dbg_ack_i   (dbg_ack)
	);

	dbg_target u_target (
		.clk         (clk),
		.reset       (reset),
		.dbg_adr_i   (dbg_adr),
		.dbg_sel_i   (dbg_sel),
		.dbg_we_i    (dbg_we),
		.dbg_wdata_i (dbg_wdata),
		.dbg_stb_i   (dbg_stb),
		.dbg_rdata_o (dbg_rdata),
		.dbg_ack_o   (dbg_ack)
	);

endmodule

// ==== test/tb_dbg_uart.sv ====
/* Host side of the UART link with tests read from test/cmd_input.txt.
   Command bytes get random idle gaps, and a missing reply byte ends the run. */
`timescale 1ns/100ps

module tb_dbg_uart;

	localparam int          BIT_CLKS   = dbg_uart_pkg::CLKS_PER_BIT;
	localparam int          MAX_BYTES  = 64;
	localparam int          WAIT_LIMIT = 6000;
	localparam int          IDLE_CHECK = 4 * BIT_CLKS;
	localparam int unsigned SEED       = 32'h27afa56e;

	logic clk;
	logic reset;
	logic endian;
	logic rx_line;
	logic tx_line;

	// current test record
	dbg_uart_pkg::byte_t cmd_bytes [MAX_BYTES];
	dbg_uart_pkg::byte_t exp_bytes [MAX_BYTES];
	int                  n_cmd;
	int                  n_exp;
	logic                next_endian;
	string               test_name;

	int   errors;
	int   test_errors;
	int   tests_run;
	int   tests_failed;
	logic timed_out;

	dbg_uart_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.endian_i  (endian),
		.uart_rx_i (rx_line),
		.uart_tx_o (tx_line)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string what, input dbg_uart_pkg::byte_t expected,
			input dbg_uart_pkg::byte_t actual);
		if (expected !== actual) begin
			$display("[FAIL] %0s: %0s expected %02h, actual %02h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	// --------------------------------------------------
	// host transmitter for 8N1 frames at the DUT bit rate
	task automatic send_bit(input logic value);
		@(posedge clk);
		rx_line <= value;
		repeat (BIT_CLKS - 1) @(posedge clk);
	endtask

	task automatic send_byte(input dbg_uart_pkg::byte_t data);
		int gap;
		gap = int'($urandom % (2 * BIT_CLKS));
		repeat (gap) @(posedge clk);
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(data[i]);
		send_bit(1'b1);
	endtask

	task automatic send_command();
		for (int i = 0; i < n_cmd; i++)
			send_byte(cmd_bytes[i]);
	endtask

	// --------------------------------------------------
	// host receiver sampling on the falling clock edge
	task automatic wait_start_bit(output logic found);
		int waited;
		waited = 0;
		found  = 1'b0;
		while (!found && waited < WAIT_LIMIT) begin
			@(negedge clk);
			if (tx_line == 1'b0)
				found = 1'b1;
			waited++;
		end
	endtask

	task automatic receive_byte(output dbg_uart_pkg::byte_t data, output logic ok);
		logic found;
		data = '0;
		ok   = 1'b0;
		wait_start_bit(found);
		if (!found) begin
			$display("No reply byte came from the DUT within %0d cycles in test %0s.",
				WAIT_LIMIT, test_name);
			timed_out = 1'b1;
			test_errors++;
		end else begin
			// move to the middle of the start bit
			repeat (BIT_CLKS / 2) @(negedge clk);
			if (tx_line !== 1'b0) begin
				$display("A start bit from the DUT was too short in test %0s.", test_name);
				test_errors++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(negedge clk);
				data[i] = tx_line;
			end
			repeat (BIT_CLKS) @(negedge clk);
			if (tx_line !== 1'b1) begin
				$display("A reply byte in test %0s ended with a low stop bit.", test_name);
				test_errors++;
			end
			ok = 1'b1;
		end
	endtask

	task automatic collect_replies();
		dbg_uart_pkg::byte_t data;
		logic                ok;
		for (int i = 0; i < n_exp && !timed_out; i++) begin
			receive_byte(data, ok);
			if (ok)
				check_value($sformatf("reply byte %0d", i), exp_bytes[i], data);
		end
	endtask

	// anything on the line now is a byte too many
	task automatic check_line_idle();
		logic extra;
		extra = 1'b0;
		repeat (IDLE_CHECK) begin
			@(negedge clk);
			if (tx_line !== 1'b1)
				extra = 1'b1;
		end
		if (extra) begin
			$display("The DUT sent more reply bytes than expected in test %0s.", test_name);
			test_errors++;
		end
	endtask

	// --------------------------------------------------
	// test records
	function automatic bit read_record(input int fd);
		string tok;
		string rest;
		int    rc;
		int    ev;
		int    val;
		rc = $fscanf(fd, "%s", tok);
		// lines starting with # are notes
		while (rc == 1 && tok.getc(0) == "#") begin
			rc = $fgets(rest, fd);
			rc = $fscanf(fd, "%s", tok);
		end
		if (rc != 1)
			return 1'b0;
		test_name = tok;
		rc = $fscanf(fd, "%d %d", ev, n_cmd);
		if (rc != 2 || n_cmd < 1 || n_cmd > MAX_BYTES) begin
			$display("Record %0s in the data file has a bad endian or byte count.", tok);
			errors++;
			return 1'b0;
		end
		next_endian = ev[0];
		for (int i = 0; i < n_cmd; i++) begin
			rc = $fscanf(fd, "%h", val);
			cmd_bytes[i] = val[7:0];
		end
		rc = $fscanf(fd, "%d", n_exp);
		if (rc != 1 || n_exp < 0 || n_exp > MAX_BYTES) begin
			$display("Record %0s in the data file has a bad reply count.", tok);
			errors++;
			return 1'b0;
		end
		for (int i = 0; i < n_exp; i++) begin
			rc = $fscanf(fd, "%h", val);
			exp_bytes[i] = val[7:0];
		end
		return 1'b1;
	endfunction

	task automatic run_test();
		test_errors = 0;
		@(posedge clk);
		endian <= next_endian;
		@(posedge clk);
		// replies may start while later command bytes are still going out
		fork
			send_command();
			collect_replies();
		join
		if (!timed_out)
			check_line_idle();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d errors", test_name, test_errors);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	initial begin
		int   fd;
		logic more;
		reset        = 1'b1;
		endian       = 1'b0;
		rx_line      = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		void'($urandom(SEED));
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (2 * BIT_CLKS) @(posedge clk);

		fd = $fopen("test/cmd_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/cmd_input.txt for reading.");
			errors++;
		end else begin
			more = read_record(fd);
			while (more && !timed_out) begin
				run_test();
				more = read_record(fd);
			end
			$fclose(fd);
		end

		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (errors == 0 && tests_failed == 0 && tests_run > 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== test/cmd_input.txt ====
# name endian n_cmd cmd_bytes n_reply reply_bytes
# counts in decimal, bytes in hex, sel/adr byte is sel in the high nibble
nop 0 1 00 1 80
status_le 0 1 01 2 81 00
status_be 1 1 01 2 81 01
dbg_write_r5 0 6 02 55 11 22 33 44 1 82
dbg_read_r5_le 0 2 03 F5 5 83 11 00 33 00
dbg_read_r5_be 1 2 03 F5 5 83 00 33 00 11
mem_write 0 12 04 05 13 00 00 00 D0 D1 D2 D3 D4 D5 1 84
mem_read 0 6 05 05 13 00 00 00 7 85 D0 D1 D2 D3 D4 D5
mem_write_swap 0 7 04 00 20 0C 0B 0A 5A 1 84
addr_read_be 1 2 03 F2 5 83 0A 0B 0C 20
addr_read_le 0 2 03 F2 5 83 20 0C 0B 0A
burst_nop 0 4 00 00 01 00 5 80 80 81 00 80
burst_mixed 0 11 00 01 03 F5 05 01 13 00 00 00 00 12 80 81 00 83 11 00 33 00 85 D0 D1 80

// ==== sources.f ====
logic/dbg_uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
logic/dbg_cmd_engine.sv
logic/dbg_target.sv
logic/dbg_uart_top.sv
test/tb_dbg_uart.sv

// ==== Makefile ====
BUILD := build

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_dbg_uart -Mdir $(BUILD) -o tb_dbg_uart
	./$(BUILD)/tb_dbg_uart > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf $(BUILD) sim.log
